// File: Makefile
# Verilator flow for the game pacing core.

TOP = game_pace_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+verilog
verilog/pace_pkg.sv
verilog/pace_if.sv
verilog/difficulty_ramp.sv
verilog/asteroid_pacer.sv
verilog/shot_pacer.sv
verilog/event_arbiter.sv
verilog/game_pace_top.sv
sim/game_pace_properties.sv
sim/game_pace_tb.sv

// File: sim/game_pace_properties.sv
// game_pace_properties concurrent checks on the arbiter and the play counter.
`timescale 1ns/1ps
`include "pace_macros.svh"

module game_pace_properties #(
    parameter int step_len = 64
) (
    input logic                   clock,
    input logic                   rst_n,
    input logic                   event_valid,
    input pace_pkg::event_kind_t  event_kind,
    input logic [`PACE_CNT_W-1:0] q,
    input logic                   ent,
    input logic                   rco
);

    localparam int max_count = `PACE_LEVELS * step_len;

    a_kind_set: assert property (@(posedge clock) disable iff (!rst_n)
        event_valid |-> event_kind != pace_pkg::ev_none)
        else $error("event_valid high with no event kind");

    a_q_saturates: assert property (@(posedge clock) disable iff (!rst_n)
        q <= max_count)
        else $error("q above saturation value");

    a_rco_needs_ent: assert property (@(posedge clock) disable iff (!rst_n)
        rco |-> ent)
        else $error("rco high without ent");

endmodule

// File: sim/game_pace_tb.sv
// game_pace_tb trace-driven testbench for game_pace_top, with the bind of the checks.
`timescale 1ns/1ps
`include "pace_macros.svh"

module game_pace_tb;

    logic                   clock;
    logic                   rst_n;
    logic                   clr, ld, ent, enp, fire;
    logic [`PACE_CNT_W-1:0] d;
    logic [`PACE_CNT_W-1:0] q;
    logic                   rco;
    logic [3:0]             level;
    logic                   event_valid;
    pace_pkg::event_kind_t  event_kind;

    int    ev_count [4];
    int    ev_start [4];
    int    errors;
    int    checks;
    int    cycle_no;
    int    limit;
    string lines [$];

    game_pace_top #(.step_len(64)) u_dut (
        .clock(clock), .rst_n(rst_n), .clr(clr), .ld(ld), .ent(ent), .enp(enp),
        .d(d), .fire(fire), .q(q), .rco(rco), .level(level),
        .event_valid(event_valid), .event_kind(event_kind)
    );

    bind game_pace_top game_pace_properties #(.step_len(step_len)) u_props (
        .clock(clock), .rst_n(rst_n), .event_valid(event_valid),
        .event_kind(event_kind), .q(q), .ent(ent), .rco(rco)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        if (event_valid)
            ev_count[event_kind] <= ev_count[event_kind] + 1;
    end

    // watchdog, armed once the trace length is known.
    always @(posedge clock) begin
        cycle_no++;
        if (limit > 0 && cycle_no > limit) begin
            $display("timeout after %0d cycles, trace did not complete", cycle_no);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_count(input string name, input logic [`PACE_CNT_W-1:0] got,
                               input logic [`PACE_CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED level got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // asteroid counts may sit one off where a tick lands on the window edge.
    task automatic check_events(input pace_pkg::event_kind_t kind, input int got,
                                input int exp);
        int tol;
        if (exp < 0)
            return;
        tol = (exp > 0 && kind != pace_pkg::ev_shot_move) ? 1 : 0;
        checks++;
        if (got < exp - tol || got > exp + tol) begin
            errors++;
            $display("FAILED %s count got 0x%h expected 0x%h", kind.name(), got, exp);
        end
    endtask

    task automatic run_command(input string cmd, input int dval, input int en,
                               input int cycles);
        @(posedge clock);
        ev_start = ev_count;
        ent  <= 1'b0;
        enp  <= 1'b0;
        clr  <= (cmd == "clear");
        ld   <= (cmd == "load");
        fire <= (cmd == "fire");
        d    <= `PACE_CNT_W'(dval);
        @(posedge clock);
        clr  <= 1'b0;
        ld   <= 1'b0;
        fire <= 1'b0;
        ent  <= en[1];
        enp  <= en[0];
        repeat (cycles) @(posedge clock);
        enp  <= 1'b0; // hold the count while results are read.
        @(negedge clock); // outputs settled.
    endtask

    initial begin
        int    fd;
        int    n;
        int    test_no;
        int    err_before;
        int    dval, en, cycles, eq, elevel, erco, esp, eas, esh;
        string line;
        string cmd;

        errors = 0;
        checks = 0;
        cycle_no = 0;
        limit = 0;
        ev_count = '{default: 0};
        rst_n = 1'b0;
        clr = 1'b0;
        ld = 1'b0;
        ent = 1'b0;
        enp = 1'b0;
        fire = 1'b0;
        d = '0;

        fd = $fopen("sim/game_pace_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open trace file sim/game_pace_trace.txt");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line[0] != "#")
                    lines.push_back(line);
            end
            $fclose(fd);
        end

        n = 0;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %d %d %d", cmd, dval, en, cycles));
            n += cycles;
        end
        limit = n + 200 + 4 * lines.size();

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        test_no = 0;
        foreach (lines[i]) begin
            test_no++;
            err_before = errors;
            n = $sscanf(lines[i], "%s %d %d %d %d %d %d %d %d %d", cmd, dval, en, cycles,
                        eq, elevel, erco, esp, eas, esh);
            if (n != 10) begin
                errors++;
                $display("test %0d: trace line could not be parsed", test_no);
            end else if (cmd != "clear" && cmd != "load" && cmd != "run" && cmd != "fire") begin
                errors++;
                $display("test %0d: unknown command %s in trace", test_no, cmd);
            end else begin
                run_command(cmd, dval, en, cycles);
                check_count("q", q, `PACE_CNT_W'(eq));
                check_level(level, 4'(elevel));
                check_flag("rco", rco, erco[0]);
                check_events(pace_pkg::ev_spawn, ev_count[1] - ev_start[1], esp);
                check_events(pace_pkg::ev_aste_move, ev_count[2] - ev_start[2], eas);
                check_events(pace_pkg::ev_shot_move, ev_count[3] - ev_start[3], esh);
                $display("test %0d %s %0d cycles: %s", test_no, cmd, cycles,
                         (errors == err_before) ? "ok" : "failed");
            end
        end

        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: sim/game_pace_trace.txt
# cmd d en(ent,enp) cycles | exp q level rco | exp spawn aste shot events
# an event count of -1 is not checked
clear 0 3 100 100 1 0 -1 -1 0
run 0 3 700 768 11 1 -1 -1 0
run 0 1 20 768 11 0 -1 -1 0
clear 0 3 10 10 0 0 -1 -1 0
run 0 2 50 10 0 0 -1 -1 0
load 63 2 2 63 0 0 -1 -1 0
load 64 2 2 64 1 0 -1 -1 0
load 703 2 2 703 10 0 -1 -1 0
load 768 2 2 768 11 1 -1 -1 0
clear 0 2 250 0 0 0 6 10 0
fire 0 2 100 0 0 0 2 4 12
fire 0 2 100 0 0 0 3 4 12
clear 0 2 100 0 0 0 -1 -1 0
run 0 2 100 0 0 0 -1 -1 0

// File: verilog/asteroid_pacer.sv
// asteroid_pacer with reloading spawn and asteroid-move down-counters.
`timescale 1ns/1ps
`include "pace_macros.svh"

module asteroid_pacer (
    input  logic  clock,
    input  logic  rst_n,
    pace_if.pacer pace,
    output logic  spawn_tick,
    output logic  aste_tick
);

    logic [`PACE_PER_W-1:0] gen_cnt;
    logic [`PACE_PER_W-1:0] aste_cnt;

    // reload picks up the latest period; an empty counter loads too.
    function automatic logic [`PACE_PER_W-1:0] next_count(
        input logic [`PACE_PER_W-1:0] cnt,
        input logic [`PACE_PER_W-1:0] per
    );
        if (cnt <= 1)
            return per;
        return cnt - 1'b1;
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            gen_cnt  <= '0;
            aste_cnt <= '0;
        end else if (pace.restart) begin
            gen_cnt  <= pace.periods.gen;
            aste_cnt <= pace.periods.aste;
        end else if (pace.period_valid) begin
            gen_cnt  <= next_count(gen_cnt, pace.periods.gen);
            aste_cnt <= next_count(aste_cnt, pace.periods.aste);
        end
    end

    assign spawn_tick = pace.period_valid && (gen_cnt == 1);
    assign aste_tick  = pace.period_valid && (aste_cnt == 1);

endmodule

// File: verilog/difficulty_ramp.sv
// difficulty_ramp play-time counter with ripple carry and level/period lookup.
`timescale 1ns/1ps
`include "pace_macros.svh"

module difficulty_ramp #(
    parameter int step_len = 64
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   clr,
    input  logic                   ld,
    input  logic                   ent,
    input  logic                   enp,
    input  logic [`PACE_CNT_W-1:0] d,
    output logic [`PACE_CNT_W-1:0] q,
    output logic                   rco,
    pace_if.ramp                   pace
);

    localparam int max_count = `PACE_LEVELS * step_len;

    logic [`PACE_CNT_W-1:0] lookup_src;
    logic [3:0]             level_next;

    function automatic pace_pkg::pace_periods_t period_row(input logic [3:0] lvl);
        case (lvl)
            4'd0:    return '{`PACE_GEN_L0,  `PACE_AST_L0,  `PACE_SHOT_L0};
            4'd1:    return '{`PACE_GEN_L1,  `PACE_AST_L1,  `PACE_SHOT_L1};
            4'd2:    return '{`PACE_GEN_L2,  `PACE_AST_L2,  `PACE_SHOT_L2};
            4'd3:    return '{`PACE_GEN_L3,  `PACE_AST_L3,  `PACE_SHOT_L3};
            4'd4:    return '{`PACE_GEN_L4,  `PACE_AST_L4,  `PACE_SHOT_L4};
            4'd5:    return '{`PACE_GEN_L5,  `PACE_AST_L5,  `PACE_SHOT_L5};
            4'd6:    return '{`PACE_GEN_L6,  `PACE_AST_L6,  `PACE_SHOT_L6};
            4'd7:    return '{`PACE_GEN_L7,  `PACE_AST_L7,  `PACE_SHOT_L7};
            4'd8:    return '{`PACE_GEN_L8,  `PACE_AST_L8,  `PACE_SHOT_L8};
            4'd9:    return '{`PACE_GEN_L9,  `PACE_AST_L9,  `PACE_SHOT_L9};
            4'd10:   return '{`PACE_GEN_L10, `PACE_AST_L10, `PACE_SHOT_L10};
            default: return '{`PACE_GEN_L11, `PACE_AST_L11, `PACE_SHOT_L11};
        endcase
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clr) begin
            q <= '0;
        end else if (ld) begin
            q <= d;
        end else if (ent && enp && q < max_count) begin
            q <= q + 1'b1;
        end
    end

    assign rco = ent && (q >= max_count);

    // a clear maps straight to level 0, so restart reloads level-0 periods.
    assign lookup_src = clr ? '0 : q;

    // no gaps at the boundaries, everything above 11 steps is level 11.
    always_comb begin
        level_next = '0;
        for (int i = 1; i < `PACE_LEVELS; i++) begin
            if (lookup_src >= i * step_len)
                level_next = 4'(i);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pace.level        <= '0;
            pace.periods      <= period_row(4'd0);
            pace.period_valid <= 1'b0;
            pace.restart      <= 1'b0;
        end else begin
            pace.level        <= level_next;
            pace.periods      <= period_row(level_next);
            pace.period_valid <= 1'b1;
            pace.restart      <= clr;
        end
    end

endmodule

// File: verilog/event_arbiter.sv
// event_arbiter merging three tick streams into one prioritized event stream.
`timescale 1ns/1ps

module event_arbiter (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  spawn_tick,
    input  logic                  aste_tick,
    input  logic                  shot_tick,
    output logic                  event_valid,
    output pace_pkg::event_kind_t event_kind
);

    logic [2:0]            pending;
    logic [2:0]            pend_all;
    logic [2:0]            grant;
    pace_pkg::event_kind_t kind_next;

    // bit 0 spawn, bit 1 asteroid move, bit 2 shot move.
    assign pend_all = pending | {shot_tick, aste_tick, spawn_tick};

    always_comb begin
        grant     = 3'b000;
        kind_next = pace_pkg::ev_none;
        if (pend_all[0]) begin
            grant     = 3'b001;
            kind_next = pace_pkg::ev_spawn;
        end else if (pend_all[1]) begin
            grant     = 3'b010;
            kind_next = pace_pkg::ev_aste_move;
        end else if (pend_all[2]) begin
            grant     = 3'b100;
            kind_next = pace_pkg::ev_shot_move;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= 3'b000;
            event_valid <= 1'b0;
            event_kind  <= pace_pkg::ev_none;
        end else begin
            pending     <= pend_all & ~grant; // a repeat tick merges into its bit.
            event_valid <= |pend_all;
            event_kind  <= kind_next;
        end
    end

endmodule

// File: verilog/game_pace_top.sv
// game_pace_top wiring the ramp, both pacers and the event arbiter.
`timescale 1ns/1ps
`include "pace_macros.svh"

module game_pace_top #(
    parameter int step_len = 64
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   clr,
    input  logic                   ld,
    input  logic                   ent,
    input  logic                   enp,
    input  logic [`PACE_CNT_W-1:0] d,
    input  logic                   fire,
    output logic [`PACE_CNT_W-1:0] q,
    output logic                   rco,
    output logic [3:0]             level,
    output logic                   event_valid,
    output pace_pkg::event_kind_t  event_kind
);

    logic spawn_tick;
    logic aste_tick;
    logic shot_tick;

    pace_if pace_bus ();

    assign level = pace_bus.level;

    difficulty_ramp #(
        .step_len(step_len)
    ) u_ramp (
        .clock (clock),
        .rst_n (rst_n),
        .clr   (clr),
        .ld    (ld),
        .ent   (ent),
        .enp   (enp),
        .d     (d),
        .q     (q),
        .rco   (rco),
        .pace  (pace_bus.ramp)
    );

    asteroid_pacer u_aste (
        .clock      (clock),
        .rst_n      (rst_n),
        .pace       (pace_bus.pacer),
        .spawn_tick (spawn_tick),
        .aste_tick  (aste_tick)
    );

    shot_pacer u_shot (
        .clock     (clock),
        .rst_n     (rst_n),
        .pace      (pace_bus.pacer),
        .fire      (fire),
        .shot_tick (shot_tick)
    );

    event_arbiter u_arb (
        .clock       (clock),
        .rst_n       (rst_n),
        .spawn_tick  (spawn_tick),
        .aste_tick   (aste_tick),
        .shot_tick   (shot_tick),
        .event_valid (event_valid),
        .event_kind  (event_kind)
    );

endmodule

// File: verilog/pace_if.sv
// pace_if carrying level, periods, period_valid and restart to the pacers.
`timescale 1ns/1ps

interface pace_if;

    logic [3:0]              level;
    pace_pkg::pace_periods_t periods;
    logic                    period_valid; // low until first lookup.
    logic                    restart;      // clr delayed one cycle.

    modport ramp (
        output level,
        output periods,
        output period_valid,
        output restart
    );

    modport pacer (
        input level,
        input periods,
        input period_valid,
        input restart
    );

endinterface

// File: verilog/pace_macros.svh
// widths, level count and per-level period constants for the pacing core.
`ifndef PACE_MACROS_SVH
`define PACE_MACROS_SVH

`define PACE_CNT_W  16
`define PACE_PER_W  16
`define PACE_LEVELS 12

// asteroid spawn period, in clock cycles.
`define PACE_GEN_L0  16'd40
`define PACE_GEN_L1  16'd38
`define PACE_GEN_L2  16'd36
`define PACE_GEN_L3  16'd34
`define PACE_GEN_L4  16'd32
`define PACE_GEN_L5  16'd30
`define PACE_GEN_L6  16'd28
`define PACE_GEN_L7  16'd26
`define PACE_GEN_L8  16'd24
`define PACE_GEN_L9  16'd22
`define PACE_GEN_L10 16'd20
`define PACE_GEN_L11 16'd18

// asteroid move period.
`define PACE_AST_L0  16'd24
`define PACE_AST_L1  16'd22
`define PACE_AST_L2  16'd21
`define PACE_AST_L3  16'd20
`define PACE_AST_L4  16'd19
`define PACE_AST_L5  16'd18
`define PACE_AST_L6  16'd16
`define PACE_AST_L7  16'd15
`define PACE_AST_L8  16'd14
`define PACE_AST_L9  16'd13
`define PACE_AST_L10 16'd12
`define PACE_AST_L11 16'd10

// shot move period, never below 3.
`define PACE_SHOT_L0  16'd8
`define PACE_SHOT_L1  16'd8
`define PACE_SHOT_L2  16'd7
`define PACE_SHOT_L3  16'd7
`define PACE_SHOT_L4  16'd7
`define PACE_SHOT_L5  16'd6
`define PACE_SHOT_L6  16'd6
`define PACE_SHOT_L7  16'd6
`define PACE_SHOT_L8  16'd5
`define PACE_SHOT_L9  16'd5
`define PACE_SHOT_L10 16'd4
`define PACE_SHOT_L11 16'd4

`endif

// File: verilog/pace_pkg.sv
// pace_pkg with the period-set struct and the event-kind enum.
`include "pace_macros.svh"

package pace_pkg;

    // one row of the period table.
    typedef struct packed {
        logic [`PACE_PER_W-1:0] gen;   // spawn.
        logic [`PACE_PER_W-1:0] aste;  // asteroid move.
        logic [`PACE_PER_W-1:0] shot;  // shot move.
    } pace_periods_t;

    typedef enum logic [1:0] {
        ev_none      = 2'd0,
        ev_spawn     = 2'd1,
        ev_aste_move = 2'd2,
        ev_shot_move = 2'd3
    } event_kind_t;

endpackage

// File: verilog/shot_pacer.sv
// shot_pacer armed down-counter for shot-move ticks.
`timescale 1ns/1ps
`include "pace_macros.svh"

module shot_pacer (
    input  logic  clock,
    input  logic  rst_n,
    pace_if.pacer pace,
    input  logic  fire,
    output logic  shot_tick
);

    logic [`PACE_PER_W-1:0] shot_cnt;
    logic                   armed;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            shot_cnt <= '0;
        end else if (pace.restart) begin
            armed    <= 1'b0; // game restart drops the shot.
            shot_cnt <= '0;
        end else if (fire) begin
            armed    <= 1'b1; // re-phase on every fire.
            shot_cnt <= pace.periods.shot;
        end else if (armed && pace.period_valid) begin
            if (shot_cnt <= 1)
                shot_cnt <= pace.periods.shot;
            else
                shot_cnt <= shot_cnt - 1'b1;
        end
    end

    assign shot_tick = armed && pace.period_valid && (shot_cnt == 1);

endmodule
